/* rtl/frm_buf_pkg.sv */
////////////////////////////////////////////////////////////
// shared geometry and types of the frame buffer stage
// buffer depth, pointer width, header field positions and
// the stream beat and frame metadata structs
// referenced by scoped name from every rtl and dv file
////////////////////////////////////////////////////////////
`default_nettype none

package frm_buf_pkg;

    ////////////////////////////////////////////////////////////
    // buffer geometry
    ////////////////////////////////////////////////////////////
    localparam int ADDR_W = 9;              // 512 qwords
    localparam int DEPTH = 1 << ADDR_W;
    localparam int PTR_W = ADDR_W + 1;      // extra wrap bit

    // 1518 byte frame -> 190 data qwords
    localparam int MAX_FRAME_QW = 190;

    ////////////////////////////////////////////////////////////
    // header qword layout
    ////////////////////////////////////////////////////////////
    localparam int HDR_LEN_LSB = 32;        // 16 bit byte length
    localparam int HDR_SRC_LSB = 0;         // 8 bit source port
    localparam int HDR_DST_LSB = 16;        // 8 bit destination port

    // qword pointer, counts modulo 2*DEPTH
    typedef logic [PTR_W-1:0] ptr_t;

    // per frame sideband, also the egress user field
    typedef struct packed {
        logic [15:0] length;                // bytes
        logic [7:0]  src_port;
        logic [7:0]  dst_port;
    } frame_meta_t;

    // one 64 bit stream beat
    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tstrb;                 // byte enables, lsb first
        logic        tlast;
    } axis_beat_t;

endpackage

`default_nettype wire

/* rtl/frm_ibuf_ram.sv */
////////////////////////////////////////////////////////////
// qword buffer ram, one write port and one read port
// read data is registered, one cycle after the address
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frm_ibuf_ram (
    input  wire logic                           clk,
    input  wire logic                           wr_en_i,
    input  wire logic [frm_buf_pkg::ADDR_W-1:0] wr_addr_i,
    input  wire logic [63:0]                    wr_data_i,
    input  wire logic [frm_buf_pkg::ADDR_W-1:0] rd_addr_i,
    output logic      [63:0]                    rd_data_o
);

    // plain array, maps onto block ram
    logic [63:0] mem [frm_buf_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];    // read before write on collision
    end

    // write address must be known on every write
    a_wr_addr_known : assert property (@(posedge clk) wr_en_i |-> !$isunknown(wr_addr_i));

    // read side is live once the writer has left reset
    a_rd_addr_known : assert property (@(posedge clk)
        !$isunknown(wr_en_i) |-> !$isunknown(rd_addr_i));

endmodule

`default_nettype wire

/* rtl/frm_rx_writer.sv */
////////////////////////////////////////////////////////////
// ingress writer, stores each frame as header + data qwords
// counts bytes from the strobes, writes the header last and
// then publishes the committed producer pointer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frm_rx_writer (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire frm_buf_pkg::axis_beat_t        s_beat_i,
    input  wire frm_buf_pkg::frame_meta_t       s_meta_i,
    input  wire logic                           s_valid_i,
    output logic                                s_ready_o,
    output logic                                wr_en_o,
    output logic      [frm_buf_pkg::ADDR_W-1:0] wr_addr_o,
    output logic      [63:0]                    wr_data_o,
    input  wire frm_buf_pkg::ptr_t              committed_cons_i,
    output frm_buf_pkg::ptr_t                   committed_prod_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_HDR} wr_state_t;

    wr_state_t                state;
    frm_buf_pkg::ptr_t        hdr_ptr;      // header slot of current frame
    frm_buf_pkg::ptr_t        beat_cnt;     // data qwords so far
    frm_buf_pkg::ptr_t        data_ptr;
    frm_buf_pkg::ptr_t        used;
    frm_buf_pkg::frame_meta_t meta_q;       // length field is the byte counter
    logic [15:0]              strb_bytes;
    logic [63:0]              hdr_word;
    logic                     space_ok;
    logic                     beat_acc;

    assign beat_acc   = s_valid_i && s_ready_o;
    assign strb_bytes = 16'($countones(s_beat_i.tstrb));
    assign data_ptr   = hdr_ptr + beat_cnt + frm_buf_pkg::ptr_t'(1);
    assign used       = hdr_ptr - committed_cons_i;
    // room for a worst case frame plus its header
    assign space_ok   = used <= frm_buf_pkg::ptr_t'(frm_buf_pkg::DEPTH -
                                                    frm_buf_pkg::MAX_FRAME_QW - 1);

    always_comb begin
        hdr_word = '0;
        hdr_word[frm_buf_pkg::HDR_LEN_LSB +: 16] = meta_q.length;
        hdr_word[frm_buf_pkg::HDR_SRC_LSB +: 8]  = meta_q.src_port;
        hdr_word[frm_buf_pkg::HDR_DST_LSB +: 8]  = meta_q.dst_port;
    end

    // data beats land after the header slot, header goes in last
    assign wr_en_o   = beat_acc || (state == ST_HDR);
    assign wr_addr_o = (state == ST_HDR) ? hdr_ptr[frm_buf_pkg::ADDR_W-1:0]
                                         : data_ptr[frm_buf_pkg::ADDR_W-1:0];
    assign wr_data_o = (state == ST_HDR) ? hdr_word : s_beat_i.tdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= ST_IDLE;
            s_ready_o        <= 1'b0;
            hdr_ptr          <= '0;
            beat_cnt         <= '0;
            committed_prod_o <= '0;
        end else begin
            case (state)
                ST_IDLE : begin
                    s_ready_o <= space_ok;          // only stall before a frame
                    if (beat_acc) begin
                        meta_q.length   <= strb_bytes;
                        meta_q.src_port <= s_meta_i.src_port;
                        meta_q.dst_port <= s_meta_i.dst_port;
                        beat_cnt        <= frm_buf_pkg::ptr_t'(1);
                        state           <= s_beat_i.tlast ? ST_HDR : ST_DATA;
                        s_ready_o       <= !s_beat_i.tlast;
                    end
                end
                ST_DATA : begin
                    if (beat_acc) begin
                        meta_q.length <= meta_q.length + strb_bytes;
                        beat_cnt      <= beat_cnt + 1'b1;
                        if (s_beat_i.tlast) begin
                            state     <= ST_HDR;
                            s_ready_o <= 1'b0;
                        end
                    end
                end
                default : begin                     // ST_HDR, header written now
                    committed_prod_o <= data_ptr;   // visible next cycle
                    hdr_ptr          <= data_ptr;
                    beat_cnt         <= '0;
                    state            <= ST_IDLE;
                end
            endcase
        end
    end

    // last beat strobes are a run of ones from byte 0
    a_strb_contig : assert property (@(posedge clk) disable iff (rst)
        beat_acc && s_beat_i.tlast |->
            (s_beat_i.tstrb != 8'h00) && ((s_beat_i.tstrb & (s_beat_i.tstrb + 9'd1)) == '0));

    // every commit step is one frame, header included
    a_frame_size : assert property (@(posedge clk) disable iff (rst)
        $changed(committed_prod_o) |->
            frm_buf_pkg::ptr_t'(committed_prod_o - $past(committed_prod_o)) <=
            frm_buf_pkg::ptr_t'(frm_buf_pkg::MAX_FRAME_QW + 1));

endmodule

`default_nettype wire

/* rtl/frm_tx_reader.sv */
////////////////////////////////////////////////////////////
// egress reader, follows the committed producer pointer,
// reads each frame header and streams the data qwords out
// with strobes, tlast and the frame metadata
// consumer pointer goes back once tlast is accepted
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frm_tx_reader (
    input  wire logic                           clk,
    input  wire logic                           rst,
    output logic      [frm_buf_pkg::ADDR_W-1:0] rd_addr_o,
    input  wire logic [63:0]                    rd_data_i,
    input  wire frm_buf_pkg::ptr_t              committed_prod_i,
    output frm_buf_pkg::ptr_t                   committed_cons_o,
    output frm_buf_pkg::axis_beat_t             m_beat_o,
    output frm_buf_pkg::frame_meta_t            m_meta_o,
    output logic                                m_valid_o,
    input  wire logic                           m_ready_i
);

    typedef enum logic [1:0] {SYN_INIT, SYN_WAIT, SYN_CALC, SYN_BUSY} syn_state_t;
    typedef enum logic [1:0] {SND_IDLE, SND_RUN, SND_LAST} snd_state_t;

    ////////////////////////////////////////////////////////////
    // frame sync
    ////////////////////////////////////////////////////////////
    syn_state_t               syn_st;
    frm_buf_pkg::ptr_t        diff;         // committed qwords not yet read
    frm_buf_pkg::ptr_t        qw_need;
    frm_buf_pkg::ptr_t        qw_len;       // data qwords of current frame
    frm_buf_pkg::frame_meta_t hdr_meta;
    logic [7:0]               last_strb;
    logic                     trig;

    ////////////////////////////////////////////////////////////
    // send side
    ////////////////////////////////////////////////////////////
    snd_state_t               snd_st;
    frm_buf_pkg::ptr_t        rd_ptr;
    frm_buf_pkg::ptr_t        qw_iss;       // reads issued, net of rewinds
    frm_buf_pkg::ptr_t        qw_ld;        // beats loaded to the output
    logic                     fetch_v;      // rd_data holds a wanted qword
    logic                     can_load;
    logic                     sync;

    assign rd_addr_o = rd_ptr[frm_buf_pkg::ADDR_W-1:0];
    assign can_load  = !m_valid_o || m_ready_i;
    // round bytes up to whole qwords
    assign qw_need   = frm_buf_pkg::ptr_t'(hdr_meta.length[15:3]) +
                       frm_buf_pkg::ptr_t'(|hdr_meta.length[2:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            syn_st <= SYN_INIT;
            diff   <= '0;
            trig   <= 1'b0;
        end else begin
            trig <= 1'b0;
            diff <= committed_prod_i - rd_ptr;
            case (syn_st)
                SYN_INIT : syn_st <= SYN_WAIT;      // first read of slot 0 in flight
                SYN_WAIT : begin
                    if (diff != '0) begin           // rd_data is the header here
                        hdr_meta.length   <= rd_data_i[frm_buf_pkg::HDR_LEN_LSB +: 16];
                        hdr_meta.src_port <= rd_data_i[frm_buf_pkg::HDR_SRC_LSB +: 8];
                        hdr_meta.dst_port <= rd_data_i[frm_buf_pkg::HDR_DST_LSB +: 8];
                        syn_st            <= SYN_CALC;
                    end
                end
                SYN_CALC : begin
                    qw_len    <= qw_need;
                    // zero low bits mean a full last qword
                    last_strb <= (hdr_meta.length[2:0] == 3'd0) ? 8'hFF
                                 : ~(8'hFF << hdr_meta.length[2:0]);
                    if (diff > qw_need) begin       // header + data all committed
                        trig   <= 1'b1;
                        syn_st <= SYN_BUSY;
                    end else begin
                        syn_st <= SYN_WAIT;
                    end
                end
                default : if (sync) syn_st <= SYN_WAIT;   // next header
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_st           <= SND_IDLE;
            rd_ptr           <= '0;
            qw_iss           <= '0;
            qw_ld            <= '0;
            fetch_v          <= 1'b0;
            sync             <= 1'b0;
            committed_cons_o <= '0;
            m_valid_o        <= 1'b0;
            m_beat_o.tlast   <= 1'b0;
        end else begin
            sync <= 1'b0;
            if (m_valid_o && m_ready_i) begin
                m_valid_o <= 1'b0;                  // reloaded below if data is there
            end
            case (snd_st)
                SND_IDLE : begin
                    qw_iss  <= '0;
                    qw_ld   <= '0;
                    fetch_v <= 1'b0;
                    if (trig) begin
                        rd_ptr   <= rd_ptr + 1'b1;  // skip the header
                        m_meta_o <= hdr_meta;
                        snd_st   <= SND_RUN;
                    end
                end
                SND_RUN : begin
                    if (fetch_v && !can_load) begin // output held, qword dropped
                        rd_ptr  <= rd_ptr - 1'b1;   // back to it, refetch
                        qw_iss  <= qw_iss - 1'b1;
                        fetch_v <= 1'b0;
                    end else begin
                        fetch_v <= (qw_iss != qw_len);
                        if (qw_iss != qw_len) begin
                            rd_ptr <= rd_ptr + 1'b1;
                            qw_iss <= qw_iss + 1'b1;
                        end
                        if (fetch_v) begin
                            m_beat_o.tdata <= rd_data_i;
                            m_beat_o.tstrb <= 8'hFF;
                            m_valid_o      <= 1'b1;
                            qw_ld          <= qw_ld + 1'b1;
                            if (qw_ld + 1'b1 == qw_len) begin
                                m_beat_o.tstrb <= last_strb;
                                m_beat_o.tlast <= 1'b1;
                                snd_st         <= SND_LAST;
                            end
                        end
                    end
                end
                default : begin                     // SND_LAST
                    if (m_ready_i) begin
                        committed_cons_o <= rd_ptr; // rd_ptr sits on next header
                        m_beat_o.tlast   <= 1'b0;
                        sync             <= 1'b1;
                        snd_st           <= SND_IDLE;
                    end
                end
            endcase
        end
    end

    // held beat must not change
    a_beat_hold : assert property (@(posedge clk) disable iff (rst)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o));

    // consumer stays behind the writer's committed pointer
    a_cons_behind : assert property (@(posedge clk) disable iff (rst)
        frm_buf_pkg::ptr_t'(committed_prod_i - committed_cons_o) <=
        frm_buf_pkg::ptr_t'(frm_buf_pkg::DEPTH));

endmodule

`default_nettype wire

/* rtl/frm_buf_top.sv */
////////////////////////////////////////////////////////////
// frame buffer stage top, writer -> qword ram -> reader
// pointers close the loop between writer and reader
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frm_buf_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire frm_buf_pkg::axis_beat_t  s_beat_i,
    input  wire frm_buf_pkg::frame_meta_t s_meta_i,
    input  wire logic                     s_valid_i,
    output logic                          s_ready_o,
    output frm_buf_pkg::axis_beat_t       m_beat_o,
    output frm_buf_pkg::frame_meta_t      m_meta_o,
    output logic                          m_valid_o,
    input  wire logic                     m_ready_i
);

    logic                           wr_en;
    logic [frm_buf_pkg::ADDR_W-1:0] wr_addr;
    logic [63:0]                    wr_data;
    logic [frm_buf_pkg::ADDR_W-1:0] rd_addr;
    logic [63:0]                    rd_data;
    frm_buf_pkg::ptr_t              committed_prod;   // writer -> reader
    frm_buf_pkg::ptr_t              committed_cons;   // reader -> writer

    frm_rx_writer writer_i (
        .clk, .rst, .s_beat_i, .s_meta_i, .s_valid_i, .s_ready_o,
        .wr_en_o (wr_en), .wr_addr_o (wr_addr), .wr_data_o (wr_data),
        .committed_cons_i (committed_cons), .committed_prod_o (committed_prod)
    );

    frm_ibuf_ram ram_i (
        .clk, .wr_en_i (wr_en), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
        .rd_addr_i (rd_addr), .rd_data_o (rd_data)
    );

    frm_tx_reader reader_i (
        .clk, .rst, .rd_addr_o (rd_addr), .rd_data_i (rd_data),
        .committed_prod_i (committed_prod), .committed_cons_o (committed_cons),
        .m_beat_o, .m_meta_o, .m_valid_o, .m_ready_i
    );

endmodule

`default_nettype wire

/* dv/frm_buf_tb.sv */
////////////////////////////////////////////////////////////
// testbench for the frame buffer stage
// pushes a table of frames into ingress and checks egress
// data, strobes, tlast and metadata in order while the
// egress ready is always on, random or held low
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frm_buf_tb;

    localparam int N_FIXED  = 14;
    localparam int N_SHORT  = 130;              // short frames, over two pointer wraps
    localparam int N_FRAMES = N_FIXED + N_SHORT;
    localparam int RDY_ALL  = 0;
    localparam int RDY_RAND = 1;
    localparam int RDY_HOLD = 2;                // egress stalled for HOLD_CYC
    localparam int HOLD_CYC = 1000;
    localparam int WAIT_MAX = 4000;             // cycle limit of every wait

    logic                     clk;
    logic                     rst;
    frm_buf_pkg::axis_beat_t  s_beat_i;
    frm_buf_pkg::frame_meta_t s_meta_i;
    logic                     s_valid_i;
    logic                     s_ready_o;
    frm_buf_pkg::axis_beat_t  m_beat_o;
    frm_buf_pkg::frame_meta_t m_meta_o;
    logic                     m_valid_o;
    logic                     m_ready_i;

    ////////////////////////////////////////////////////////////
    // frame table, one row per frame
    ////////////////////////////////////////////////////////////
    int         len_tab  [N_FRAMES];            // bytes
    logic [7:0] src_tab  [N_FRAMES];
    logic [7:0] dst_tab  [N_FRAMES];
    int         mode_tab [N_FRAMES];            // egress ready mode

    int seed      = 42;
    int cur_frame = 0;                          // frame at the egress head
    int hold_cnt  = 0;
    int stall_cnt = 0;                          // long waits before a first beat

    frm_buf_top dut_i (
        .clk, .rst, .s_beat_i, .s_meta_i, .s_valid_i, .s_ready_o,
        .m_beat_o, .m_meta_o, .m_valid_o, .m_ready_i
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_equal(input logic [79:0] got, input logic [79:0] exp,
                               input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s, got %0h expected %0h",
                                $time, what, got, exp));
        end
    endtask

    task automatic set_row(input int idx, input int len, input int src, input int dst,
                           input int mode);
        len_tab[idx]  = len;
        src_tab[idx]  = 8'(src);
        dst_tab[idx]  = 8'(dst);
        mode_tab[idx] = mode;
    endtask

    task automatic build_table();
        int i;
        set_row(0, 64, 1, 2, RDY_ALL);
        set_row(1, 65, 3, 4, RDY_ALL);
        set_row(2, 71, 5, 6, RDY_ALL);
        set_row(3, 1518, 7, 8, RDY_ALL);        // largest frame
        set_row(4, 8, 9, 10, RDY_ALL);          // one full beat
        set_row(5, 1, 11, 12, RDY_ALL);         // one byte
        set_row(6, 64, 13, 14, RDY_RAND);
        set_row(7, 65, 15, 16, RDY_RAND);
        set_row(8, 71, 17, 18, RDY_RAND);
        set_row(9, 1518, 19, 20, RDY_RAND);
        set_row(10, 1518, 21, 22, RDY_HOLD);    // buffer fills behind this one
        set_row(11, 1518, 23, 24, RDY_ALL);
        set_row(12, 1518, 25, 26, RDY_ALL);
        set_row(13, 1518, 27, 28, RDY_RAND);
        for (i = 0; i < N_SHORT; i++) begin
            set_row(N_FIXED + i, 57 + (i % 16), i, 255 - i, (i % 3 == 0) ? RDY_RAND : RDY_ALL);
        end
    endtask

    function automatic int beats_of(input int f);
        return (len_tab[f] + 7) / 8;
    endfunction

    function automatic frm_buf_pkg::frame_meta_t meta_of(input int f);
        frm_buf_pkg::frame_meta_t m;
        m.length   = 16'(len_tab[f]);
        m.src_port = src_tab[f];
        m.dst_port = dst_tab[f];
        return m;
    endfunction

    // data from frame and beat index, strobe from the byte length
    function automatic frm_buf_pkg::axis_beat_t make_beat(input int f, input int b);
        frm_buf_pkg::axis_beat_t beat;
        int rem;
        rem        = len_tab[f] % 8;
        beat.tdata = {16'(f), 16'(b), ~16'(f), 16'hC0DE ^ 16'(b)};
        beat.tlast = (b == beats_of(f) - 1);
        beat.tstrb = 8'hFF;
        if (beat.tlast && rem != 0) begin
            beat.tstrb = 8'hFF >> (8 - rem);    // partial last qword
        end
        return beat;
    endfunction

    ////////////////////////////////////////////////////////////
    // ingress driver
    ////////////////////////////////////////////////////////////
    task automatic send_frame(input int f);
        int b;
        int cyc;
        for (b = 0; b < beats_of(f); b++) begin
            s_beat_i  <= make_beat(f, b);
            s_meta_i  <= meta_of(f);
            s_valid_i <= 1'b1;
            cyc = 0;
            @(negedge clk);
            while (!s_ready_o) begin
                if (b != 0) begin
                    abort_run($sformatf("s_ready_o dropped in the middle of frame %0d", f));
                end
                cyc++;
                if (cyc > WAIT_MAX) begin
                    abort_run("timeout while ingress waited for s_ready_o");
                end
                @(negedge clk);
            end
            if (cyc > 4) begin
                stall_cnt++;                    // longer than the header gap
            end
            @(posedge clk);                     // beat taken here
        end
    endtask

    ////////////////////////////////////////////////////////////
    // egress checker
    ////////////////////////////////////////////////////////////
    task automatic wait_egress_beat();
        frm_buf_pkg::axis_beat_t held_beat;
        logic                    held;
        int                      cyc;
        held = 1'b0;
        cyc  = 0;
        @(negedge clk);
        while (!(m_valid_o && m_ready_i)) begin
            if (m_valid_o) begin
                if (held) begin
                    check_equal(80'(m_beat_o), 80'(held_beat), "held egress beat changed");
                end
                held_beat = m_beat_o;
                held      = 1'b1;
            end
            cyc++;
            if (cyc > WAIT_MAX) begin
                abort_run("timeout while the checker waited for an egress beat");
            end
            @(negedge clk);
        end
        if (held) begin
            check_equal(80'(m_beat_o), 80'(held_beat), "held egress beat changed");
        end
    endtask

    task automatic check_frame(input int f);
        frm_buf_pkg::axis_beat_t  exp_beat;
        frm_buf_pkg::frame_meta_t exp_meta;
        int                       b;
        cur_frame = f;                          // selects the ready mode
        exp_meta  = meta_of(f);
        for (b = 0; b < beats_of(f); b++) begin
            exp_beat = make_beat(f, b);
            wait_egress_beat();
            check_equal(80'(m_beat_o.tdata), 80'(exp_beat.tdata),
                        $sformatf("frame %0d beat %0d tdata", f, b));
            check_equal(80'(m_beat_o.tstrb), 80'(exp_beat.tstrb),
                        $sformatf("frame %0d beat %0d tstrb", f, b));
            check_equal(80'(m_beat_o.tlast), 80'(exp_beat.tlast),
                        $sformatf("frame %0d beat %0d tlast", f, b));
            check_equal(80'(m_meta_o), 80'(exp_meta), $sformatf("frame %0d meta", f));
        end
    endtask

    // egress ready follows the mode of the head frame
    initial begin
        m_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                m_ready_i <= 1'b0;
            end else if (mode_tab[cur_frame] == RDY_RAND) begin
                m_ready_i <= 1'($random(seed));
            end else if (mode_tab[cur_frame] == RDY_HOLD && hold_cnt < HOLD_CYC) begin
                m_ready_i <= 1'b0;
                hold_cnt++;
            end else begin
                m_ready_i <= 1'b1;
            end
        end
    end

    initial begin
        int fi;
        int fc;
        rst       = 1'b1;
        s_valid_i = 1'b0;
        s_beat_i  = '0;
        s_meta_i  = '0;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(80'(s_ready_o), 80'(0), "s_ready_o right after reset");
        check_equal(80'(m_beat_o.tlast), 80'(0), "tlast right after reset");
        repeat (12) begin                       // empty buffer, nothing leaves
            check_equal(80'(m_valid_o), 80'(0), "m_valid_o with no frame stored");
            @(negedge clk);
        end
        @(posedge clk);
        fork
            begin
                for (fi = 0; fi < N_FRAMES; fi++) begin
                    send_frame(fi);
                end
                s_valid_i <= 1'b0;
            end
            begin
                for (fc = 0; fc < N_FRAMES; fc++) begin
                    check_frame(fc);
                end
            end
        join
        repeat (20) begin
            @(negedge clk);
            check_equal(80'(m_valid_o), 80'(0), "extra egress beat after the last frame");
        end
        check_equal(80'(stall_cnt != 0), 80'(1), "ingress never stalled under egress hold");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/frm_buf_pkg.sv
rtl/frm_ibuf_ram.sv
rtl/frm_rx_writer.sv
rtl/frm_tx_reader.sv
rtl/frm_buf_top.sv
dv/frm_buf_tb.sv

/* Makefile */
# Verilator build and run of the frame buffer stage testbench
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= frm_buf_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
